//--- design/mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [npc_mem_pkg::ADDR_W-1:0] if_read_addr_i,
  input  logic                           if_valid_i,
  input  logic [npc_mem_pkg::MASK_W-1:0] if_rmask_i,
  output logic [npc_mem_pkg::XLEN-1:0]   if_rdata_o,
  output logic                           if_rdata_valid_o,
  input  logic [npc_mem_pkg::ADDR_W-1:0] mem_read_addr_i,
  input  logic                           mem_valid_i,
  input  logic [npc_mem_pkg::MASK_W-1:0] mem_rmask_i,
  output logic [npc_mem_pkg::XLEN-1:0]   mem_rdata_o,
  output logic                           mem_rdata_valid_o,
  input  logic [npc_mem_pkg::ADDR_W-1:0] mem_write_addr_i,
  input  logic                           mem_write_valid_i,
  input  logic [npc_mem_pkg::MASK_W-1:0] mem_wmask_i,
  input  logic [npc_mem_pkg::XLEN-1:0]   mem_wdata_i,
  output logic                           mem_wdata_ready_o
);

  ram_rd_if i_rd_if ();
  ram_wr_if i_wr_if ();

  // arbitration and sequencing
  ram_arb i_ram_arb (
    .clk               (clk),
    .rst               (rst),
    .if_read_addr_i    (if_read_addr_i),
    .if_valid_i        (if_valid_i),
    .if_rmask_i        (if_rmask_i),
    .if_rdata_o        (if_rdata_o),
    .if_rdata_valid_o  (if_rdata_valid_o),
    .mem_read_addr_i   (mem_read_addr_i),
    .mem_valid_i       (mem_valid_i),
    .mem_rmask_i       (mem_rmask_i),
    .mem_rdata_o       (mem_rdata_o),
    .mem_rdata_valid_o (mem_rdata_valid_o),
    .mem_write_addr_i  (mem_write_addr_i),
    .mem_write_valid_i (mem_write_valid_i),
    .mem_wmask_i       (mem_wmask_i),
    .mem_wdata_i       (mem_wdata_i),
    .mem_wdata_ready_o (mem_wdata_ready_o),
    .rd                (i_rd_if.arb),
    .wr                (i_wr_if.arb)
  );

  // backing store
  pmem i_pmem (
    .clk (clk),
    .rst (rst),
    .rd  (i_rd_if.mem),
    .wr  (i_wr_if.mem)
  );

endmodule

//--- design/npc_mem_pkg.sv
package npc_mem_pkg;

  // datapath widths
  localparam int XLEN   = 64;
  localparam int ADDR_W = 32;
  localparam int BYTE_W = 8;
  localparam int MASK_W = XLEN / BYTE_W;

  // backing store geometry, word index sits above the byte offset
  localparam int MEM_DEPTH   = 1024;
  localparam int WORD_IDX_LO = $clog2(MASK_W);
  localparam int WORD_IDX_W  = $clog2(MEM_DEPTH);

  // sequencer states, shared by the read and the write FSM
  localparam int ST_W = 2;
  localparam logic [ST_W-1:0] ST_IDLE    = 2'd0;
  localparam logic [ST_W-1:0] ST_ISSUE   = 2'd1;
  localparam logic [ST_W-1:0] ST_RESP    = 2'd2;
  localparam logic [ST_W-1:0] ST_PREIDLE = 2'd3;

  // one double word, seen whole or as byte lanes
  typedef union packed {
    logic [XLEN-1:0]                dword;
    logic [MASK_W-1:0][BYTE_W-1:0]  lanes;
  } xlen_word_u;

endpackage

//--- design/pmem.sv
`timescale 1ns/1ps

module pmem (
  input  logic   clk,
  input  logic   rst,
  ram_rd_if.mem  rd,
  ram_wr_if.mem  wr
);

  logic [npc_mem_pkg::XLEN-1:0]       mem_q [npc_mem_pkg::MEM_DEPTH];
  logic [npc_mem_pkg::WORD_IDX_W-1:0] wr_idx;
  logic [npc_mem_pkg::WORD_IDX_W-1:0] rd_idx;
  npc_mem_pkg::xlen_word_u            wr_old_w;
  npc_mem_pkg::xlen_word_u            wr_new_w;
  npc_mem_pkg::xlen_word_u            wr_merged_w;
  npc_mem_pkg::xlen_word_u            rd_word_w;
  npc_mem_pkg::xlen_word_u            rd_masked_w;
  logic [npc_mem_pkg::XLEN-1:0]       rd_data_q;
  logic                               rd_data_valid_q;
  logic                               wr_done_q;

  // address bits above the word index simply wrap
  assign wr_idx = wr.wr_addr[npc_mem_pkg::WORD_IDX_LO +: npc_mem_pkg::WORD_IDX_W];
  assign rd_idx = rd.rd_addr[npc_mem_pkg::WORD_IDX_LO +: npc_mem_pkg::WORD_IDX_W];

  initial begin
    for (int i = 0; i < npc_mem_pkg::MEM_DEPTH; i++) begin
      mem_q[i] = '0;
    end
  end

  // lane merge for writes, lane zeroing for reads
  always_comb begin
    wr_old_w.dword = mem_q[wr_idx];
    wr_new_w.dword = wr.wr_data;
    rd_word_w.dword = mem_q[rd_idx];
    for (int i = 0; i < npc_mem_pkg::MASK_W; i++) begin
      wr_merged_w.lanes[i] = wr.wr_mask[i] ? wr_new_w.lanes[i] : wr_old_w.lanes[i];
      rd_masked_w.lanes[i] = rd.rd_mask[i] ? rd_word_w.lanes[i] : '0;
    end
  end

  always @(posedge clk) begin
    if (wr.wr_valid) begin
      mem_q[wr_idx] <= wr_merged_w.dword;
    end
  end

  // read sees the array before a same-edge write
  always_ff @(posedge clk) begin
    if (rd.rd_valid) begin
      rd_data_q <= rd_masked_w.dword;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_data_valid_q <= 1'b0;
      wr_done_q       <= 1'b0;
    end else begin
      rd_data_valid_q <= rd.rd_valid;
      wr_done_q       <= wr.wr_valid;
    end
  end

  assign rd.rd_data       = rd_data_q;
  assign rd.rd_data_valid = rd_data_valid_q;
  assign wr.wr_done       = wr_done_q;

  // strobes come from the arbiter and must be clean once out of reset
  a_strobes_known: assert property (
    @(posedge clk) disable iff (rst) !$isunknown({rd.rd_valid, wr.wr_valid})
  );

endmodule

//--- design/ram_arb.sv
`timescale 1ns/1ps

module ram_arb (
  input  logic                           clk,
  input  logic                           rst,
  // instruction fetch read port
  input  logic [npc_mem_pkg::ADDR_W-1:0] if_read_addr_i,
  input  logic                           if_valid_i,
  input  logic [npc_mem_pkg::MASK_W-1:0] if_rmask_i,
  output logic [npc_mem_pkg::XLEN-1:0]   if_rdata_o,
  output logic                           if_rdata_valid_o,
  // mem stage read port
  input  logic [npc_mem_pkg::ADDR_W-1:0] mem_read_addr_i,
  input  logic                           mem_valid_i,
  input  logic [npc_mem_pkg::MASK_W-1:0] mem_rmask_i,
  output logic [npc_mem_pkg::XLEN-1:0]   mem_rdata_o,
  output logic                           mem_rdata_valid_o,
  // mem stage write port, not shared
  input  logic [npc_mem_pkg::ADDR_W-1:0] mem_write_addr_i,
  input  logic                           mem_write_valid_i,
  input  logic [npc_mem_pkg::MASK_W-1:0] mem_wmask_i,
  input  logic [npc_mem_pkg::XLEN-1:0]   mem_wdata_i,
  output logic                           mem_wdata_ready_o,
  ram_rd_if.arb                          rd,
  ram_wr_if.arb                          wr
);

  logic [npc_mem_pkg::ST_W-1:0]   rd_state_q;
  logic                           rd_valid_q;
  // 1 while fetch owns the outstanding read, 0 for the mem stage
  logic                           owner_if_q;
  logic [npc_mem_pkg::ADDR_W-1:0] rd_addr_q;
  logic [npc_mem_pkg::MASK_W-1:0] rd_mask_q;
  logic                           resp_fire;
  logic                           if_hit;
  logic                           mem_hit;

  logic [npc_mem_pkg::ST_W-1:0]   wr_state_q;
  logic [npc_mem_pkg::ADDR_W-1:0] wr_addr_q;
  logic [npc_mem_pkg::MASK_W-1:0] wr_mask_q;
  logic [npc_mem_pkg::XLEN-1:0]   wr_data_q;

  // read sequencer, fetch wins a tie
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_state_q <= npc_mem_pkg::ST_PREIDLE;
      rd_valid_q <= 1'b0;
      owner_if_q <= 1'b0;
    end else begin
      rd_valid_q <= 1'b0;
      case (rd_state_q)
        npc_mem_pkg::ST_PREIDLE: begin
          rd_state_q <= npc_mem_pkg::ST_IDLE;
        end
        npc_mem_pkg::ST_IDLE: begin
          if (if_valid_i || mem_valid_i) begin
            owner_if_q <= if_valid_i;
            rd_valid_q <= 1'b1;
            rd_state_q <= npc_mem_pkg::ST_ISSUE;
          end
        end
        npc_mem_pkg::ST_ISSUE: begin
          rd_state_q <= npc_mem_pkg::ST_RESP;
        end
        default: begin
          // RESP, nothing new is taken on this edge
          rd_state_q <= npc_mem_pkg::ST_IDLE;
        end
      endcase
    end
  end

  // request payload captured with the grant
  always_ff @(posedge clk) begin
    if (rd_state_q == npc_mem_pkg::ST_IDLE) begin
      if (if_valid_i) begin
        rd_addr_q <= if_read_addr_i;
        rd_mask_q <= if_rmask_i;
      end else if (mem_valid_i) begin
        rd_addr_q <= mem_read_addr_i;
        rd_mask_q <= mem_rmask_i;
      end
    end
  end

  assign rd.rd_valid = rd_valid_q;
  assign rd.rd_addr  = rd_addr_q;
  assign rd.rd_mask  = rd_mask_q;

  // response goes back only while its owner still holds valid
  assign resp_fire = (rd_state_q == npc_mem_pkg::ST_RESP) && rd.rd_data_valid;
  assign if_hit    = resp_fire && owner_if_q && if_valid_i;
  assign mem_hit   = resp_fire && !owner_if_q && mem_valid_i;

  assign if_rdata_valid_o  = if_hit;
  assign mem_rdata_valid_o = mem_hit;
  assign if_rdata_o        = if_hit ? rd.rd_data : '0;
  assign mem_rdata_o       = mem_hit ? rd.rd_data : '0;

  // write sequencer
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_state_q <= npc_mem_pkg::ST_PREIDLE;
    end else begin
      case (wr_state_q)
        npc_mem_pkg::ST_PREIDLE: begin
          wr_state_q <= npc_mem_pkg::ST_IDLE;
        end
        npc_mem_pkg::ST_IDLE: begin
          if (mem_write_valid_i) begin
            wr_state_q <= npc_mem_pkg::ST_ISSUE;
          end
        end
        npc_mem_pkg::ST_ISSUE: begin
          wr_state_q <= npc_mem_pkg::ST_RESP;
        end
        default: begin
          wr_state_q <= npc_mem_pkg::ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_state_q == npc_mem_pkg::ST_IDLE && mem_write_valid_i) begin
      wr_addr_q <= mem_write_addr_i;
      wr_mask_q <= mem_wmask_i;
      wr_data_q <= mem_wdata_i;
    end
  end

  // a write whose valid has gone by ISSUE is dropped
  assign wr.wr_valid = (wr_state_q == npc_mem_pkg::ST_ISSUE) && mem_write_valid_i;
  assign wr.wr_addr  = wr_addr_q;
  assign wr.wr_mask  = wr_mask_q;
  assign wr.wr_data  = wr_data_q;

  assign mem_wdata_ready_o = wr.wr_done;

  a_one_read_resp: assert property (
    @(posedge clk) disable iff (rst) !(if_rdata_valid_o && mem_rdata_valid_o)
  );

  a_ready_single: assert property (
    @(posedge clk) disable iff (rst) mem_wdata_ready_o |=> !mem_wdata_ready_o
  );

  a_rd_valid_in_issue: assert property (
    @(posedge clk) disable iff (rst) rd.rd_valid |-> (rd_state_q == npc_mem_pkg::ST_ISSUE)
  );

endmodule

//--- design/ram_rd_if.sv
`timescale 1ns/1ps

interface ram_rd_if;

  // request side, owned by the arbiter
  logic                           rd_valid;
  logic [npc_mem_pkg::ADDR_W-1:0] rd_addr;
  logic [npc_mem_pkg::MASK_W-1:0] rd_mask;

  // registered return from the memory
  logic [npc_mem_pkg::XLEN-1:0]   rd_data;
  logic                           rd_data_valid;

  modport arb (
    output rd_valid,
    output rd_addr,
    output rd_mask,
    input  rd_data,
    input  rd_data_valid
  );

  modport mem (
    input  rd_valid,
    input  rd_addr,
    input  rd_mask,
    output rd_data,
    output rd_data_valid
  );

endinterface

//--- design/ram_wr_if.sv
`timescale 1ns/1ps

interface ram_wr_if;

  logic                           wr_valid;
  logic [npc_mem_pkg::ADDR_W-1:0] wr_addr;
  logic [npc_mem_pkg::MASK_W-1:0] wr_mask;
  logic [npc_mem_pkg::XLEN-1:0]   wr_data;
  // pulses on the edge where the write lands in the array
  logic                           wr_done;

  modport arb (
    output wr_valid,
    output wr_addr,
    output wr_mask,
    output wr_data,
    input  wr_done
  );

  modport mem (
    input  wr_valid,
    input  wr_addr,
    input  wr_mask,
    input  wr_data,
    output wr_done
  );

endinterface

//--- list.f
design/npc_mem_pkg.sv
design/ram_rd_if.sv
design/ram_wr_if.sv
design/ram_arb.sv
design/pmem.sv
design/mem_subsys_top.sv
verification/tb_clk_gen.sv
verification/tb_mem_checks.sv
verification/tb_mem_subsys.sv

//--- verification/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  localparam int HALF_PERIOD = 4;

  initial begin
    clk_o = 1'b0;
    forever begin
      #HALF_PERIOD;
      clk_o = ~clk_o;
    end
  end

  // reset spans the first three rising edges
  initial begin
    rst_o = 1'b1;
    repeat (3) @(posedge clk_o);
    #1;
    rst_o = 1'b0;
  end

endmodule

//--- verification/tb_mem_checks.sv
`timescale 1ns/1ps

module tb_mem_checks (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        if_req_i,
  input  logic        mem_req_i,
  input  logic        wr_req_i,
  input  logic        if_rvalid_i,
  input  logic        mem_rvalid_i,
  input  logic        wready_i,
  input  logic [63:0] if_rdata_i,
  input  logic [63:0] mem_rdata_i,
  input  logic [63:0] exp_if_data_i,
  input  logic [63:0] exp_mem_data_i,
  output int          err_cnt_o
);

  logic req_seen;

  initial begin
    err_cnt_o = 0;
  end

  task automatic log_mismatch(input string name, input logic [63:0] exp, input logic [63:0] act);
    $display("CHECK FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
    err_cnt_o++;
  endtask

  task automatic log_rule(input string what);
    $display("protocol error at t=%0t: %s", $time, what);
    err_cnt_o++;
  endtask

  // sticky once any requester has asked for something
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      req_seen <= 1'b0;
    end else if (if_req_i || mem_req_i || wr_req_i) begin
      req_seen <= 1'b1;
    end
  end

  a_quiet_until_request: assert property (@(posedge clk_i) disable iff (rst_i)
    !req_seen |-> !(if_rvalid_i || mem_rvalid_i || wready_i))
    else log_rule("response strobe seen before the first request");

  a_write_latency: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(wr_req_i) |-> !wready_i ##1 !wready_i ##1 wready_i)
    else log_rule("write ready not exactly two edges after the request");

  // fetch wins, so its answer is the first read strobe
  a_if_latency: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(if_req_i) |-> !(if_rvalid_i || mem_rvalid_i) [*2] ##1 if_rvalid_i)
    else log_rule("fetch read answer not first or not two edges after the request");

  a_mem_latency: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(mem_req_i) && !if_req_i |-> !(if_rvalid_i || mem_rvalid_i) [*2] ##1 mem_rvalid_i)
    else log_rule("mem read answer not two edges after the request");

  a_one_read_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    !(if_rvalid_i && mem_rvalid_i))
    else log_rule("both read valids high in the same cycle");

  a_if_data: assert property (@(posedge clk_i) disable iff (rst_i)
    if_rvalid_i |-> if_rdata_i == exp_if_data_i)
    else log_mismatch("if_rdata_o", $sampled(exp_if_data_i), $sampled(if_rdata_i));

  a_mem_data: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_rvalid_i |-> mem_rdata_i == exp_mem_data_i)
    else log_mismatch("mem_rdata_o", $sampled(exp_mem_data_i), $sampled(mem_rdata_i));

endmodule

//--- verification/tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys;

  localparam int TIMEOUT  = 20;
  localparam int N_RANDOM = 80;

  logic                           clk;
  logic                           rst;
  logic [npc_mem_pkg::ADDR_W-1:0] if_read_addr_i;
  logic                           if_valid_i;
  logic [npc_mem_pkg::MASK_W-1:0] if_rmask_i;
  logic [npc_mem_pkg::XLEN-1:0]   if_rdata_o;
  logic                           if_rdata_valid_o;
  logic [npc_mem_pkg::ADDR_W-1:0] mem_read_addr_i;
  logic                           mem_valid_i;
  logic [npc_mem_pkg::MASK_W-1:0] mem_rmask_i;
  logic [npc_mem_pkg::XLEN-1:0]   mem_rdata_o;
  logic                           mem_rdata_valid_o;
  logic [npc_mem_pkg::ADDR_W-1:0] mem_write_addr_i;
  logic                           mem_write_valid_i;
  logic [npc_mem_pkg::MASK_W-1:0] mem_wmask_i;
  logic [npc_mem_pkg::XLEN-1:0]   mem_wdata_i;
  logic                           mem_wdata_ready_o;
  logic [npc_mem_pkg::XLEN-1:0]   exp_if_data;
  logic [npc_mem_pkg::XLEN-1:0]   exp_mem_data;
  npc_mem_pkg::xlen_word_u        model_mem [npc_mem_pkg::MEM_DEPTH];
  npc_mem_pkg::xlen_word_u        wr_word;
  int                             chk_err;
  int                             timeout_err;
  integer                         seed;

  tb_clk_gen i_clk_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  mem_subsys_top i_dut (.*);

  tb_mem_checks i_checks (
    .clk_i          (clk),
    .rst_i          (rst),
    .if_req_i       (if_valid_i),
    .mem_req_i      (mem_valid_i),
    .wr_req_i       (mem_write_valid_i),
    .if_rvalid_i    (if_rdata_valid_o),
    .mem_rvalid_i   (mem_rdata_valid_o),
    .wready_i       (mem_wdata_ready_o),
    .if_rdata_i     (if_rdata_o),
    .mem_rdata_i    (mem_rdata_o),
    .exp_if_data_i  (exp_if_data),
    .exp_mem_data_i (exp_mem_data),
    .err_cnt_o      (chk_err)
  );

  // 8 bytes per word and the higher address bits wrap around the array
  function automatic int word_index(input logic [31:0] addr);
    return (addr / 8) % npc_mem_pkg::MEM_DEPTH;
  endfunction

  function automatic logic [63:0] model_read(input logic [31:0] addr, input logic [7:0] mask);
    npc_mem_pkg::xlen_word_u w;
    w = model_mem[word_index(addr)];
    for (int i = 0; i < npc_mem_pkg::MASK_W; i++) begin
      if (!mask[i]) begin
        w.lanes[i] = '0;
      end
    end
    return w.dword;
  endfunction

  // model follows each committed write lane by lane
  always @(negedge clk) begin
    if (!rst && mem_wdata_ready_o) begin
      wr_word = model_mem[word_index(mem_write_addr_i)];
      for (int i = 0; i < npc_mem_pkg::MASK_W; i++) begin
        if (mem_wmask_i[i]) begin
          wr_word.lanes[i] = mem_wdata_i[8*i +: 8];
        end
      end
      model_mem[word_index(mem_write_addr_i)] = wr_word;
    end
  end

  task automatic set_read(input logic to_if, input logic [31:0] addr, input logic [7:0] mask);
    if (to_if) begin
      if_read_addr_i = addr;
      if_rmask_i     = mask;
      exp_if_data    = model_read(addr, mask);
    end else begin
      mem_read_addr_i = addr;
      mem_rmask_i     = mask;
      exp_mem_data    = model_read(addr, mask);
    end
  endtask

  task automatic set_write(input logic [31:0] addr, input logic [7:0] mask,
                           input logic [63:0] data);
    mem_write_addr_i = addr;
    mem_wmask_i      = mask;
    mem_wdata_i      = data;
  endtask

  // raise the chosen valids and drop each one on the edge after its pulse
  task automatic run_requests(input logic do_wr, input logic do_if, input logic do_mem);
    int   n;
    logic got_wr;
    logic got_if;
    logic got_mem;
    @(posedge clk);
    #1;
    n = 0;
    mem_write_valid_i = do_wr;
    if_valid_i        = do_if;
    mem_valid_i       = do_mem;
    while ((mem_write_valid_i || if_valid_i || mem_valid_i) && n < TIMEOUT) begin
      @(negedge clk);
      n++;
      got_wr  = mem_wdata_ready_o;
      got_if  = if_rdata_valid_o;
      got_mem = mem_rdata_valid_o;
      @(posedge clk);
      #1;
      if (got_wr) begin
        mem_write_valid_i = 1'b0;
      end
      if (got_if) begin
        if_valid_i = 1'b0;
      end
      if (got_mem) begin
        mem_valid_i = 1'b0;
      end
    end
    if (mem_write_valid_i || if_valid_i || mem_valid_i) begin
      $display("timeout at t=%0t: no response within %0d cycles", $time, TIMEOUT);
      timeout_err++;
      mem_write_valid_i = 1'b0;
      if_valid_i        = 1'b0;
      mem_valid_i       = 1'b0;
    end
  endtask

  initial begin
    logic [31:0] pick;
    logic [31:0] addr;
    logic [7:0]  mask;
    int          n;
    seed        = 32'he0b0_e3d0;
    timeout_err = 0;
    for (int i = 0; i < npc_mem_pkg::MEM_DEPTH; i++) begin
      model_mem[i].dword = '0;
    end
    if_valid_i        = 1'b0;
    mem_valid_i       = 1'b0;
    mem_write_valid_i = 1'b0;
    set_read(1'b1, '0, '0);
    set_read(1'b0, '0, '0);
    set_write('0, '0, '0);
    n = 0;
    while (rst !== 1'b0 && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (rst !== 1'b0) begin
      $display("reset was never released");
      timeout_err++;
    end
    // quiet stretch where nothing may answer yet
    repeat (4) @(posedge clk);
    #1;
    set_write(32'h0000_0100, 8'hff, 64'h0123_4567_89ab_cdef);
    run_requests(1'b1, 1'b0, 1'b0);
    set_read(1'b0, 32'h0000_0100, 8'hff);
    run_requests(1'b0, 1'b0, 1'b1);
    // partial write and partial read of the same word
    set_write(32'h0000_0100, 8'h35, 64'hfeed_face_dead_beef);
    run_requests(1'b1, 1'b0, 1'b0);
    set_read(1'b0, 32'h0000_0100, 8'hf0);
    run_requests(1'b0, 1'b0, 1'b1);
    set_read(1'b1, 32'h0000_0100, 8'hff);
    run_requests(1'b0, 1'b1, 1'b0);
    // both read ports from one edge with 0x2108 aliasing 0x108
    set_write(32'h0000_0108, 8'hff, 64'h1111_2222_3333_4444);
    run_requests(1'b1, 1'b0, 1'b0);
    set_read(1'b1, 32'h0000_0100, 8'hff);
    set_read(1'b0, 32'h0000_2108, 8'h0f);
    run_requests(1'b0, 1'b1, 1'b1);
    // random mix over eight words with random upper bits
    for (int k = 0; k < N_RANDOM; k++) begin
      pick = $random(seed);
      addr = $random(seed) & 32'hffff_e038;
      mask = $random(seed);
      case (pick[1:0])
        2'd0: begin
          set_write(addr, mask, {$random(seed), $random(seed)});
          run_requests(1'b1, 1'b0, 1'b0);
        end
        2'd1: begin
          set_read(1'b1, addr, mask);
          run_requests(1'b0, 1'b1, 1'b0);
        end
        2'd2: begin
          set_read(1'b0, addr, mask);
          run_requests(1'b0, 1'b0, 1'b1);
        end
        default: begin
          set_read(1'b1, addr, mask);
          set_read(1'b0, addr ^ 32'h0000_2008, ~mask);
          run_requests(1'b0, 1'b1, 1'b1);
        end
      endcase
    end
    repeat (4) @(posedge clk);
    $display("errors: %0d check, %0d timeout", chk_err, timeout_err);
    if (chk_err == 0 && timeout_err == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
